//--- Makefile
TOP = lsuTb

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --assert --top-module $(TOP) -f compile.f

sim:
	verilator --binary --timing --assert --top-module $(TOP) -f compile.f -o lsuSim
	./obj_dir/lsuSim | tee /dev/stderr | grep -q "^TEST PASSED$$"

clean:
	rm -rf obj_dir

//--- common/execIf.sv
// one executed memory operation as steered to a load or store path

`timescale 1ns/1ns

interface execIf
	import lsuCfgPkg::*, lsuPktPkg::*;
();

	logic                valid;
	memOpE               op;
	logic [SEQ_W-1:0]    seqNo;
	logic [PREG_W-1:0]   phyDest;
	logic [LSQ_ID_W-1:0] ldqId;
	logic [LSQ_ID_W-1:0] stqId;   // store index, or the store bound of a load
	logic [ADDR_W-1:0]   addr;
	logic [DATA_W-1:0]   data;

	// datapath side
	modport steer (
		output valid, op, seqNo, phyDest, ldqId, stqId, addr, data
	);

	// load and store paths
	modport path (
		input  valid, op, seqNo, phyDest, ldqId, stqId, addr, data
	);

endinterface

//--- common/lsuCfgPkg.sv
// queue sizing and field width constants for the load-store unit

package lsuCfgPkg;

	// entries in each of the load and store queues
	localparam int LSQ_DEPTH = 8;

	// queue index, wraps with the depth
	localparam int LSQ_ID_W  = 3;

	// word data and byte address
	localparam int DATA_W    = 32;
	localparam int ADDR_W    = 32;

	// program order tag from the core
	localparam int SEQ_W     = 8;

	// physical register index for load results
	localparam int PREG_W    = 6;

endpackage

//--- common/lsuPktPkg.sv
// operation and drain state enums, writeback, violation and queue entry structs

package lsuPktPkg;

	import lsuCfgPkg::*;

	typedef enum logic {
		opLoad  = 1'b0,
		opStore = 1'b1
	} memOpE;

	// store drain to memory
	typedef enum logic {
		csIdle  = 1'b0,
		csWrite = 1'b1
	} commitStateE;

	typedef struct packed {
		logic                valid;
		logic                isLoad;
		logic [SEQ_W-1:0]    seqNo;
		logic [PREG_W-1:0]   phyDest;
		logic [DATA_W-1:0]   data;
	} wbPkt;

	typedef struct packed {
		logic                valid;
		logic [SEQ_W-1:0]    seqNo;     // oldest violating load
	} vioPkt;

	typedef struct packed {
		logic                addrValid; // store has executed
		logic [ADDR_W-1:0]   addr;
		logic [DATA_W-1:0]   data;
	} stqEntry;

	typedef struct packed {
		logic                executed;  // load has read memory
		logic [ADDR_W-1:0]   addr;
		logic [SEQ_W-1:0]    seqNo;
		logic [LSQ_ID_W-1:0] stqBound;  // store tail seen at dispatch
	} ldqEntry;

endpackage

//--- compile.f
common/lsuCfgPkg.sv
common/lsuPktPkg.sv
common/execIf.sv
lsu/lsuControl.sv
lsu/ldxPath.sv
lsu/stxPath.sv
lsu/lsuDatapath.sv
src/lsuTop.sv
sim/lsuTb_assert.sv
sim/lsuTb.sv

//--- lsu/ldxPath.sv
// store queue, store-to-load forwarding, memory load port and store drain FSM

`timescale 1ns/1ns

module ldxPath
	import lsuCfgPkg::*, lsuPktPkg::*;
(
	input  logic                clk,
	input  logic                rstN_i,
	execIf.path                 ldExec,
	execIf.path                 stExec,
	input  logic                stqAlloc_i,
	input  logic [LSQ_ID_W-1:0] stqHead_i,
	input  logic [LSQ_ID_W-1:0] stqTail_i,
	input  logic                recoverFlag_i,
	input  logic                commitSt_i,
	output logic [DATA_W-1:0]   loadData_o,
	output logic                ldEn_o,
	output logic [ADDR_W-1:0]   ldAddr_o,
	input  logic [DATA_W-1:0]   ldData_i,
	output logic                stEn_o,
	output logic [ADDR_W-1:0]   stAddr_o,
	output logic [DATA_W-1:0]   stData_o,
	input  logic                stStall_i,
	output logic                stallStCommit_o,
	output logic                stDrained_o
);

stqEntry           stq [LSQ_DEPTH];
commitStateE       state;
logic              drainLive;  // drained store still owns the queue head
logic              ldGo;
logic              stGo;
logic              fwdHit;
logic [DATA_W-1:0] fwdData;

assign ldGo = ldExec.valid & (ldExec.op == opLoad);
assign stGo = stExec.valid & (stExec.op == opStore);

// executed stores fill in their entry
always_ff @(posedge clk)
begin
	if (!rstN_i || recoverFlag_i)
	begin
		for (int i = 0; i < LSQ_DEPTH; i++)
			stq[i].addrValid <= 1'b0;
	end
	else
	begin
		if (stqAlloc_i)
			stq[stqTail_i].addrValid <= 1'b0;
		if (stGo)
		begin
			stq[stExec.stqId].addrValid <= 1'b1;
			stq[stExec.stqId].addr      <= stExec.addr;
			stq[stExec.stqId].data      <= stExec.data;
		end
	end
end

// walk head to bound, the last match is the youngest older store
always_comb
begin
	logic [LSQ_ID_W-1:0] idx;
	logic [LSQ_ID_W-1:0] span;
	fwdHit  = 1'b0;
	fwdData = '0;
	span    = ldExec.stqId - stqHead_i;
	for (int k = 0; k < LSQ_DEPTH; k++)
	begin
		idx = stqHead_i + LSQ_ID_W'(k);
		if ((k < int'(span)) && stq[idx].addrValid &&
		    (stq[idx].addr[ADDR_W-1:2] == ldExec.addr[ADDR_W-1:2]))
		begin
			fwdHit  = 1'b1;
			fwdData = stq[idx].data;
		end
	end
end

assign ldEn_o     = ldGo;
assign ldAddr_o   = ldExec.addr;
assign loadData_o = fwdHit ? fwdData : ldData_i;

always_ff @(posedge clk)
begin
	if (!rstN_i)
	begin
		state     <= csIdle;
		drainLive <= 1'b0;
	end
	else
	begin
		case (state)
			csIdle:
				if (commitSt_i && !recoverFlag_i)
				begin
					state     <= csWrite;
					drainLive <= 1'b1;
				end
			csWrite:
			begin
				if (!stStall_i)
					state <= csIdle;
				// queue is gone but the write still finishes
				if (recoverFlag_i)
					drainLive <= 1'b0;
			end
		endcase
	end
end

// head store latched at commit, held through stall
always_ff @(posedge clk)
begin
	if (state == csIdle && commitSt_i)
	begin
		stAddr_o <= stq[stqHead_i].addr;
		stData_o <= stq[stqHead_i].data;
	end
end

assign stEn_o          = (state == csWrite);
assign stallStCommit_o = (state == csWrite);
assign stDrained_o     = stEn_o & ~stStall_i & drainLive;

endmodule

//--- lsu/lsuControl.sv
// load and store queue head, tail and occupancy tracking with allocation

`timescale 1ns/1ns

module lsuControl
	import lsuCfgPkg::*, lsuPktPkg::*;
(
	input  logic                clk,
	input  logic                rstN_i,
	input  logic                dispatchValid_i,
	input  memOpE               dispatchOp_i,
	input  logic                recoverFlag_i,
	input  logic                commitLd_i,
	input  logic                stDrained_i,
	output logic [LSQ_ID_W-1:0] ldqHead_o,
	output logic [LSQ_ID_W-1:0] ldqTail_o,
	output logic [LSQ_ID_W-1:0] stqHead_o,
	output logic [LSQ_ID_W-1:0] stqTail_o,
	output logic                lsqFull_o,
	output logic                ldqAlloc_o,
	output logic                stqAlloc_o
);

// index 0 is the load queue, index 1 the store queue
logic [LSQ_ID_W-1:0] head  [2];
logic [LSQ_ID_W-1:0] tail  [2];
logic [LSQ_ID_W:0]   count [2];
logic [1:0]          full;
logic [1:0]          alloc;
logic [1:0]          free;

assign alloc[0] = dispatchValid_i & (dispatchOp_i == opLoad) & ~full[0];
assign alloc[1] = dispatchValid_i & (dispatchOp_i == opStore) & ~full[1];

assign free[0]  = commitLd_i;   // load retires at commit
assign free[1]  = stDrained_i;  // store leaves once memory took it

for (genvar q = 0; q < 2; q++)
begin : gQueue
	assign full[q] = (count[q] == (LSQ_ID_W+1)'(LSQ_DEPTH));

	always_ff @(posedge clk)
	begin
		if (!rstN_i || recoverFlag_i)
		begin
			head[q]  <= '0;
			tail[q]  <= '0;
			count[q] <= '0;
		end
		else
		begin
			if (alloc[q])
				tail[q] <= tail[q] + 1'b1;
			if (free[q])
				head[q] <= head[q] + 1'b1;
			count[q] <= count[q] + (LSQ_ID_W+1)'(alloc[q]) - (LSQ_ID_W+1)'(free[q]);
		end
	end
end

// full flag follows the op being dispatched
assign lsqFull_o  = (dispatchOp_i == opLoad) ? full[0] : full[1];

assign ldqAlloc_o = alloc[0];
assign stqAlloc_o = alloc[1];
assign ldqHead_o  = head[0];
assign ldqTail_o  = tail[0];
assign stqHead_o  = head[1];
assign stqTail_o  = tail[1];

endmodule

//--- lsu/lsuDatapath.sv
// operation steering to the load and store paths, registered writeback

`timescale 1ns/1ns

module lsuDatapath
	import lsuCfgPkg::*, lsuPktPkg::*;
(
	input  logic                clk,
	input  logic                rstN_i,
	input  logic                recoverFlag_i,
	input  logic [SEQ_W-1:0]    dispatchSeqNo_i,
	input  logic                execValid_i,
	input  memOpE               execOp_i,
	input  logic [SEQ_W-1:0]    execSeqNo_i,
	input  logic [PREG_W-1:0]   execPhyDest_i,
	input  logic [LSQ_ID_W-1:0] execLdqId_i,
	input  logic [LSQ_ID_W-1:0] execStqId_i,
	input  logic [ADDR_W-1:0]   execAddr_i,
	input  logic [DATA_W-1:0]   execData_i,
	input  logic                ldqAlloc_i,
	input  logic                stqAlloc_i,
	input  logic [LSQ_ID_W-1:0] ldqHead_i,
	input  logic [LSQ_ID_W-1:0] ldqTail_i,
	input  logic [LSQ_ID_W-1:0] stqHead_i,
	input  logic [LSQ_ID_W-1:0] stqTail_i,
	input  logic                commitSt_i,
	output wbPkt                wbPkt_o,
	output vioPkt               vioPkt_o,
	output logic                ldEn_o,
	output logic [ADDR_W-1:0]   ldAddr_o,
	input  logic [DATA_W-1:0]   ldData_i,
	output logic                stEn_o,
	output logic [ADDR_W-1:0]   stAddr_o,
	output logic [DATA_W-1:0]   stData_o,
	input  logic                stStall_i,
	output logic                stDrained_o,
	output logic                stallStCommit_o
);

execIf ldExec ();
execIf stExec ();

logic [DATA_W-1:0] loadData;

// load side
assign ldExec.valid   = execValid_i & (execOp_i == opLoad);
assign ldExec.op      = execOp_i;
assign ldExec.seqNo   = execSeqNo_i;
assign ldExec.phyDest = execPhyDest_i;
assign ldExec.ldqId   = execLdqId_i;
assign ldExec.stqId   = execStqId_i;  // store bound from dispatch
assign ldExec.addr    = execAddr_i;
assign ldExec.data    = execData_i;

// store side
assign stExec.valid   = execValid_i & (execOp_i == opStore);
assign stExec.op      = execOp_i;
assign stExec.seqNo   = execSeqNo_i;
assign stExec.phyDest = execPhyDest_i;
assign stExec.ldqId   = execLdqId_i;
assign stExec.stqId   = execStqId_i;
assign stExec.addr    = execAddr_i;
assign stExec.data    = execData_i;

// writeback one cycle after execute, stores carry no result
always_ff @(posedge clk)
begin
	if (!rstN_i)
		wbPkt_o.valid <= 1'b0;
	else
		wbPkt_o.valid <= ldExec.valid | stExec.valid;
	wbPkt_o.isLoad  <= ldExec.valid;
	wbPkt_o.seqNo   <= execSeqNo_i;
	wbPkt_o.phyDest <= ldExec.valid ? ldExec.phyDest : '0;
	wbPkt_o.data    <= ldExec.valid ? loadData : '0;
end

ldxPath ldx (
	.clk             (clk),
	.rstN_i          (rstN_i),
	.ldExec          (ldExec),
	.stExec          (stExec),
	.stqAlloc_i      (stqAlloc_i),
	.stqHead_i       (stqHead_i),
	.stqTail_i       (stqTail_i),
	.recoverFlag_i   (recoverFlag_i),
	.commitSt_i      (commitSt_i),
	.loadData_o      (loadData),
	.ldEn_o          (ldEn_o),
	.ldAddr_o        (ldAddr_o),
	.ldData_i        (ldData_i),
	.stEn_o          (stEn_o),
	.stAddr_o        (stAddr_o),
	.stData_o        (stData_o),
	.stStall_i       (stStall_i),
	.stallStCommit_o (stallStCommit_o),
	.stDrained_o     (stDrained_o)
);

// violation is already registered inside the store path
stxPath stx (
	.clk             (clk),
	.rstN_i          (rstN_i),
	.ldExec          (ldExec),
	.stExec          (stExec),
	.ldqAlloc_i      (ldqAlloc_i),
	.stqTail_i       (stqTail_i),
	.dispatchSeqNo_i (dispatchSeqNo_i),
	.ldqHead_i       (ldqHead_i),
	.ldqTail_i       (ldqTail_i),
	.recoverFlag_i   (recoverFlag_i),
	.vioPkt_o        (vioPkt_o)
);

endmodule

//--- lsu/stxPath.sv
// load queue with executed addresses and store-load ordering violation check

`timescale 1ns/1ns

module stxPath
	import lsuCfgPkg::*, lsuPktPkg::*;
(
	input  logic                clk,
	input  logic                rstN_i,
	execIf.path                 ldExec,
	execIf.path                 stExec,
	input  logic                ldqAlloc_i,
	input  logic [LSQ_ID_W-1:0] stqTail_i,
	input  logic [SEQ_W-1:0]    dispatchSeqNo_i,
	input  logic [LSQ_ID_W-1:0] ldqHead_i,
	input  logic [LSQ_ID_W-1:0] ldqTail_i,
	input  logic                recoverFlag_i,
	output vioPkt               vioPkt_o
);

ldqEntry          ldq [LSQ_DEPTH];
logic             ldGo;
logic             stGo;
logic             vioHit;
logic [SEQ_W-1:0] vioSeq;

assign ldGo = ldExec.valid & (ldExec.op == opLoad);
assign stGo = stExec.valid & (stExec.op == opStore);

always_ff @(posedge clk)
begin
	if (!rstN_i || recoverFlag_i)
	begin
		for (int i = 0; i < LSQ_DEPTH; i++)
			ldq[i].executed <= 1'b0;
	end
	else
	begin
		if (ldqAlloc_i)
		begin
			ldq[ldqTail_i].executed <= 1'b0;
			ldq[ldqTail_i].seqNo    <= dispatchSeqNo_i;
			ldq[ldqTail_i].stqBound <= stqTail_i;  // stores before this are older
		end
		if (ldGo)
		begin
			ldq[ldExec.ldqId].executed <= 1'b1;
			ldq[ldExec.ldqId].addr     <= ldExec.addr;
		end
	end
end

// age measured back from the store tail, a smaller distance is younger
// first hit from the load head is the oldest offender
always_comb
begin
	logic [LSQ_ID_W-1:0] idx;
	logic [LSQ_ID_W-1:0] span;
	logic [LSQ_ID_W-1:0] stAge;
	logic [LSQ_ID_W-1:0] ldAge;
	vioHit = 1'b0;
	vioSeq = '0;
	span   = ldqTail_i - ldqHead_i;
	stAge  = stqTail_i - stExec.stqId;
	for (int k = 0; k < LSQ_DEPTH; k++)
	begin
		idx   = ldqHead_i + LSQ_ID_W'(k);
		ldAge = stqTail_i - ldq[idx].stqBound;
		if (!vioHit && (k < int'(span)) && ldq[idx].executed && (ldAge < stAge) &&
		    (ldq[idx].addr[ADDR_W-1:2] == stExec.addr[ADDR_W-1:2]))
		begin
			vioHit = 1'b1;
			vioSeq = ldq[idx].seqNo;
		end
	end
end

always_ff @(posedge clk)
begin
	if (!rstN_i || recoverFlag_i)
		vioPkt_o.valid <= 1'b0;
	else
		vioPkt_o.valid <= stGo & vioHit;
	vioPkt_o.seqNo <= vioSeq;
end

endmodule

//--- sim/lsuTb.sv
// testbench for the load-store unit with memory model, queue mirror and directed tests

`timescale 1ns/1ns

module lsuTb
	import lsuCfgPkg::*, lsuPktPkg::*;
();

localparam int TEST_CYCLES = 8 * 66 + 150;  // eight drains at most plus directed traffic

logic clk = 1'b0;
logic rstN_i, dispatchValid_i, execValid_i, commitLd_i, commitSt_i, recoverFlag_i, stStall_i;
memOpE dispatchOp_i, execOp_i;
logic [SEQ_W-1:0] dispatchSeqNo_i, execSeqNo_i, wbSeqNo_o, vioSeqNo_o;
logic [PREG_W-1:0] execPhyDest_i, wbPhyDest_o;
logic [LSQ_ID_W-1:0] execLdqId_i, execStqId_i, ldqId_o, stqId_o;
logic [ADDR_W-1:0] execAddr_i, ldAddr_o, stAddr_o;
logic [DATA_W-1:0] execData_i, wbData_o, ldData_i, stData_o;
logic lsqFull_o, wbValid_o, wbIsLoad_o, vioValid_o, ldEn_o, stEn_o, stallStCommit_o;

logic [DATA_W-1:0] mem [256];
// store queue mirror
logic [ADDR_W-1:0] stAddrM [LSQ_DEPTH];
logic [DATA_W-1:0] stDataM [LSQ_DEPTH];
logic              stExecM [LSQ_DEPTH];
logic [LSQ_ID_W-1:0] stHeadM, stTailM, ldTailM;
int errors = 0;
int checks = 0;
int tests  = 0;
int errAtStart;

lsuTop uut (.*);

bind lsuTop lsuTbAssert chk (.clk(clk), .rstN_i(rstN_i), .execValid_i(execValid_i),
	.execOp_i(execOp_i), .execSeqNo_i(execSeqNo_i), .commitSt_i(commitSt_i),
	.recoverFlag_i(recoverFlag_i), .wbValid_o(wbValid_o), .wbIsLoad_o(wbIsLoad_o),
	.wbSeqNo_o(wbSeqNo_o), .ldEn_o(ldEn_o), .stEn_o(stEn_o), .stAddr_o(stAddr_o),
	.stData_o(stData_o), .stStall_i(stStall_i), .stallStCommit_o(stallStCommit_o));

always #4 clk = ~clk;

always_comb ldData_i = mem[ldAddr_o[9:2]];  // asynchronous read port

always @(posedge clk)
	if (stEn_o && !stStall_i)
		mem[stAddr_o[9:2]] <= stData_o;

task automatic checkEq(input string name, input logic [31:0] got, input logic [31:0] exp);
	checks++;
	assert (got === exp)
	else
	begin
		$display("FAILED %s got %h expected %h", name, got, exp);
		errors++;
	end
endtask

// youngest executed older store from the head up to the bound, else memory
function automatic logic [DATA_W-1:0] refLoad(input logic [LSQ_ID_W-1:0] bound,
		input logic [ADDR_W-1:0] addr);
	logic [DATA_W-1:0]   d;
	logic [LSQ_ID_W-1:0] i;
	d = mem[addr[9:2]];
	for (i = stHeadM; i != bound; i++)
		if (stExecM[i] && stAddrM[i][ADDR_W-1:2] == addr[ADDR_W-1:2])
			d = stDataM[i];
	return d;
endfunction

task automatic dispatch(input memOpE op, input logic [SEQ_W-1:0] seq,
		output logic [LSQ_ID_W-1:0] id, output logic [LSQ_ID_W-1:0] bound);
	@(posedge clk);
	dispatchValid_i <= 1'b1;
	dispatchOp_i    <= op;
	dispatchSeqNo_i <= seq;
	@(negedge clk);
	checkEq("lsqFull_o", 32'(lsqFull_o), 0);
	id    = (op == opLoad) ? ldqId_o : stqId_o;
	bound = stqId_o;
	checkEq(op == opLoad ? "ldqId_o" : "stqId_o", 32'(id),
		32'(op == opLoad ? ldTailM : stTailM));
	if (op == opLoad)
		ldTailM++;
	else
	begin
		stExecM[stTailM] = 1'b0;
		stTailM++;
	end
	@(posedge clk);
	dispatchValid_i <= 1'b0;
endtask

task automatic execute(input memOpE op, input logic [SEQ_W-1:0] seq, input logic [PREG_W-1:0] pd,
		input logic [LSQ_ID_W-1:0] ldqId, input logic [LSQ_ID_W-1:0] stqId,
		input logic [ADDR_W-1:0] addr, input logic [DATA_W-1:0] data,
		input logic expVio, input logic [SEQ_W-1:0] vioSeq);
	logic [DATA_W-1:0] expData;
	@(posedge clk);
	execValid_i <= 1'b1;
	execOp_i <= op;
	execSeqNo_i <= seq;
	execPhyDest_i <= pd;
	execLdqId_i <= ldqId;
	execStqId_i <= stqId;
	execAddr_i <= addr;
	execData_i <= data;
	expData = refLoad(stqId, addr);
	@(posedge clk);
	execValid_i <= 1'b0;
	@(negedge clk);
	checkEq("wbValid_o", 32'(wbValid_o), 1);
	checkEq("wbIsLoad_o", 32'(wbIsLoad_o), 32'(op == opLoad));
	checkEq("wbSeqNo_o", 32'(wbSeqNo_o), 32'(seq));
	if (op == opLoad)
	begin
		checkEq("wbPhyDest_o", 32'(wbPhyDest_o), 32'(pd));
		checkEq("wbData_o", wbData_o, expData);
	end
	else
	begin
		checkEq("vioValid_o", 32'(vioValid_o), 32'(expVio));
		if (expVio)
			checkEq("vioSeqNo_o", 32'(vioSeqNo_o), 32'(vioSeq));
		stAddrM[stqId] = addr;
		stDataM[stqId] = data;
		stExecM[stqId] = 1'b1;
	end
endtask

// retire the load queue head
task automatic commitLoad();
	@(posedge clk);
	commitLd_i <= 1'b1;
	@(posedge clk);
	commitLd_i <= 1'b0;
endtask

task automatic flushQueues();
	@(posedge clk);
	recoverFlag_i <= 1'b1;
	@(posedge clk);
	recoverFlag_i <= 1'b0;
endtask

// commit the head store and drain it under random stall
task automatic drainStore();
	int  cnt;
	logic done;
	cnt = 0;
	done = 1'b0;
	@(posedge clk);
	commitSt_i <= 1'b1;
	@(posedge clk);
	commitSt_i <= 1'b0;
	stStall_i  <= 1'($urandom_range(0, 1));
	while (!done && cnt < 64)
	begin
		@(negedge clk);
		done = stEn_o && !stStall_i;
		@(posedge clk);
		stStall_i <= done ? 1'b0 : 1'($urandom_range(0, 1));
		cnt++;
	end
	@(negedge clk);
	checks++;
	if (!done)
	begin
		$display("store drain did not finish within 64 cycles");
		errors++;
	end
	checkEq("mem", mem[stAddrM[stHeadM][9:2]], stDataM[stHeadM]);
	stHeadM++;
endtask

task automatic report(input string name);
	tests++;
	if (errors == errAtStart)
		$display("test %0d %s: ok", tests, name);
	else
		$display("test %0d %s: %0d error(s)", tests, name, errors - errAtStart);
	errAtStart = errors;
endtask

initial
begin
	#(TEST_CYCLES * 8 + 200 * 8);
	$display("watchdog: run did not end within %0d cycles", TEST_CYCLES + 200);
	$display("TEST FAILED");
	$finish;
end

initial
begin
	logic [LSQ_ID_W-1:0] id [6];
	logic [LSQ_ID_W-1:0] bnd [6];
	logic [ADDR_W-1:0]   a, a4, b, a3;
	int w;
	void'($urandom(32'h707b_fa83));
	for (int i = 0; i < 256; i++)
		mem[i] = 32'h5a00_0000 ^ (i * 32'h0001_0307) ^ (i << 20);
	{rstN_i, dispatchValid_i, execValid_i, commitLd_i, commitSt_i, recoverFlag_i} <= '0;
	stStall_i <= 1'b0;
	dispatchOp_i <= opLoad;
	execOp_i <= opLoad;
	{dispatchSeqNo_i, execSeqNo_i, execPhyDest_i, execLdqId_i, execStqId_i} <= '0;
	{execAddr_i, execData_i} <= '0;
	{stHeadM, stTailM, ldTailM} = '0;
	errAtStart = 0;
	repeat (2) @(posedge clk);
	rstN_i <= 1'b1;
	w  = $urandom_range(0, 63);
	a  = ADDR_W'(w * 4);
	a4 = ADDR_W'((w + 64) * 4);
	b  = ADDR_W'((w + 128) * 4);
	a3 = ADDR_W'((w + 192) * 4);

	dispatch(opLoad, 8'd1, id[0], bnd[0]);
	execute(opLoad, 8'd1, 6'd9, id[0], bnd[0], ADDR_W'($urandom_range(0, 255) * 4), '0, 0, 0);
	commitLoad();
	report("load from memory");

	for (int i = 0; i < 3; i++)
		dispatch(opStore, 8'(10 + i), id[i], bnd[i]);
	dispatch(opLoad, 8'd13, id[3], bnd[3]);
	dispatch(opStore, 8'd14, id[4], bnd[4]);
	for (int i = 0; i < 3; i++)
		execute(opStore, 8'(10 + i), '0, '0, id[i], a, $urandom, 0, 0);
	execute(opStore, 8'd14, '0, '0, id[4], a, $urandom, 0, 0);
	execute(opLoad, 8'd13, 6'd21, id[3], bnd[3], a, '0, 0, 0);
	commitLoad();
	report("store forwarding");

	dispatch(opStore, 8'd20, id[0], bnd[0]);
	execute(opStore, 8'd20, '0, '0, id[0], a3, $urandom, 0, 0);
	report("store writeback");

	dispatch(opStore, 8'd30, id[0], bnd[0]);
	dispatch(opStore, 8'd31, id[1], bnd[1]);
	dispatch(opLoad, 8'd32, id[2], bnd[2]);
	dispatch(opLoad, 8'd33, id[3], bnd[3]);
	execute(opLoad, 8'd32, 6'd4, id[2], bnd[2], a4, '0, 0, 0);
	execute(opLoad, 8'd33, 6'd5, id[3], bnd[3], a4, '0, 0, 0);
	execute(opStore, 8'd31, '0, '0, id[1], b, $urandom, 0, 0);
	execute(opStore, 8'd30, '0, '0, id[0], a4, $urandom, 1, 8'd32);
	commitLoad();
	commitLoad();
	report("ordering violation");

	dispatch(opStore, 8'd40, id[0], bnd[0]);
	execute(opStore, 8'd40, '0, '0, id[0], b, $urandom, 0, 0);
	@(posedge clk);
	dispatchOp_i <= opStore;
	@(negedge clk);
	checkEq("lsqFull_o", 32'(lsqFull_o), 1);
	drainStore();
	checkEq("lsqFull_o", 32'(lsqFull_o), 0);
	for (int i = 0; i < LSQ_DEPTH - 1; i++)
		drainStore();
	report("store drain");

	// flushed load sits younger than store slot zero
	dispatch(opStore, 8'd49, id[1], bnd[1]);
	dispatch(opLoad, 8'd50, id[0], bnd[0]);
	execute(opLoad, 8'd50, 6'd7, id[0], bnd[0], a3, '0, 0, 0);
	flushQueues();
	{stHeadM, stTailM, ldTailM} = '0;
	dispatch(opStore, 8'd60, id[0], bnd[0]);
	dispatch(opLoad, 8'd61, id[1], bnd[1]);
	execute(opStore, 8'd60, '0, '0, id[0], a3, $urandom, 0, 0);
	report("recovery");

	repeat (2) @(posedge clk);
	$display("tests %0d, checks %0d, errors %0d, assertion failures %0d",
		tests, checks, errors, uut.chk.failCount);
	if (errors == 0 && uut.chk.failCount == 0)
		$display("TEST PASSED");
	else
		$display("TEST FAILED");
	$finish;
end

endmodule

//--- sim/lsuTb_assert.sv
// concurrent checks on writeback timing, load port, store drain and reset state

`timescale 1ns/1ns

module lsuTbAssert
	import lsuCfgPkg::*, lsuPktPkg::*;
(
	input logic              clk,
	input logic              rstN_i,
	input logic              execValid_i,
	input memOpE             execOp_i,
	input logic [SEQ_W-1:0]  execSeqNo_i,
	input logic              commitSt_i,
	input logic              recoverFlag_i,
	input logic              wbValid_o,
	input logic              wbIsLoad_o,
	input logic [SEQ_W-1:0]  wbSeqNo_o,
	input logic              ldEn_o,
	input logic              stEn_o,
	input logic [ADDR_W-1:0] stAddr_o,
	input logic [DATA_W-1:0] stData_o,
	input logic              stStall_i,
	input logic              stallStCommit_o
);

int failCount = 0;  // count of failed checks

// writeback exactly one cycle after execute
wbOneCycle: assert property (@(posedge clk) disable iff (!rstN_i)
	execValid_i |=> wbValid_o && (wbSeqNo_o == $past(execSeqNo_i)))
	else
	begin
		$error("writeback missing one cycle after execute");
		failCount++;
	end

wbNone: assert property (@(posedge clk) disable iff (!rstN_i)
	!execValid_i |=> !wbValid_o)
	else
	begin
		$error("writeback without execute");
		failCount++;
	end

wbKind: assert property (@(posedge clk) disable iff (!rstN_i)
	execValid_i |=> (wbIsLoad_o == ($past(execOp_i) == opLoad)))
	else
	begin
		$error("writeback load flag wrong");
		failCount++;
	end

// memory read only in the execute cycle of a load
ldPort: assert property (@(posedge clk) disable iff (!rstN_i)
	ldEn_o == (execValid_i && execOp_i == opLoad))
	else
	begin
		$error("load port enable wrong");
		failCount++;
	end

// stalled store keeps its request on the bus
drainHold: assert property (@(posedge clk) disable iff (!rstN_i)
	stEn_o && stStall_i |=> stEn_o && $stable(stAddr_o) && $stable(stData_o))
	else
	begin
		$error("store request changed under stall");
		failCount++;
	end

drainStart: assert property (@(posedge clk) disable iff (!rstN_i)
	commitSt_i && !stallStCommit_o && !recoverFlag_i |=> stEn_o && stallStCommit_o)
	else
	begin
		$error("accepted store commit did not start the drain");
		failCount++;
	end

// write taken by memory ends the drain
drainEnd: assert property (@(posedge clk) disable iff (!rstN_i)
	stEn_o && !stStall_i |=> !stEn_o && !stallStCommit_o)
	else
	begin
		$error("store drain did not end after the write");
		failCount++;
	end

resetQuiet: assert property (@(posedge clk)
	$rose(rstN_i) |-> !wbValid_o && !stEn_o && !stallStCommit_o)
	else
	begin
		$error("outputs active after reset");
		failCount++;
	end

endmodule

//--- src/lsuTop.sv
// load-store unit top level joining queue control and datapath

`timescale 1ns/1ns

module lsuTop
	import lsuCfgPkg::*, lsuPktPkg::*;
(
	input  logic                clk,
	input  logic                rstN_i,
	input  logic                dispatchValid_i,
	input  memOpE               dispatchOp_i,
	input  logic [SEQ_W-1:0]    dispatchSeqNo_i,
	output logic                lsqFull_o,
	output logic [LSQ_ID_W-1:0] ldqId_o,
	output logic [LSQ_ID_W-1:0] stqId_o,
	input  logic                execValid_i,
	input  memOpE               execOp_i,
	input  logic [SEQ_W-1:0]    execSeqNo_i,
	input  logic [PREG_W-1:0]   execPhyDest_i,
	input  logic [LSQ_ID_W-1:0] execLdqId_i,
	input  logic [LSQ_ID_W-1:0] execStqId_i,
	input  logic [ADDR_W-1:0]   execAddr_i,
	input  logic [DATA_W-1:0]   execData_i,
	input  logic                commitLd_i,
	input  logic                commitSt_i,
	input  logic                recoverFlag_i,
	output logic                wbValid_o,
	output logic                wbIsLoad_o,
	output logic [SEQ_W-1:0]    wbSeqNo_o,
	output logic [PREG_W-1:0]   wbPhyDest_o,
	output logic [DATA_W-1:0]   wbData_o,
	output logic                vioValid_o,
	output logic [SEQ_W-1:0]    vioSeqNo_o,
	output logic                ldEn_o,
	output logic [ADDR_W-1:0]   ldAddr_o,
	input  logic [DATA_W-1:0]   ldData_i,
	output logic                stEn_o,
	output logic [ADDR_W-1:0]   stAddr_o,
	output logic [DATA_W-1:0]   stData_o,
	input  logic                stStall_i,
	output logic                stallStCommit_o
);

logic [LSQ_ID_W-1:0] ldqHead;
logic [LSQ_ID_W-1:0] ldqTail;
logic [LSQ_ID_W-1:0] stqHead;
logic [LSQ_ID_W-1:0] stqTail;
logic                ldqAlloc;
logic                stqAlloc;
logic                stDrained;
wbPkt                wb;
vioPkt               vio;

lsuControl ctrl (
	.clk             (clk),
	.rstN_i          (rstN_i),
	.dispatchValid_i (dispatchValid_i),
	.dispatchOp_i    (dispatchOp_i),
	.recoverFlag_i   (recoverFlag_i),
	.commitLd_i      (commitLd_i),
	.stDrained_i     (stDrained),
	.ldqHead_o       (ldqHead),
	.ldqTail_o       (ldqTail),
	.stqHead_o       (stqHead),
	.stqTail_o       (stqTail),
	.lsqFull_o       (lsqFull_o),
	.ldqAlloc_o      (ldqAlloc),
	.stqAlloc_o      (stqAlloc)
);

lsuDatapath dp (
	.clk             (clk),
	.rstN_i          (rstN_i),
	.recoverFlag_i   (recoverFlag_i),
	.dispatchSeqNo_i (dispatchSeqNo_i),
	.execValid_i     (execValid_i),
	.execOp_i        (execOp_i),
	.execSeqNo_i     (execSeqNo_i),
	.execPhyDest_i   (execPhyDest_i),
	.execLdqId_i     (execLdqId_i),
	.execStqId_i     (execStqId_i),
	.execAddr_i      (execAddr_i),
	.execData_i      (execData_i),
	.ldqAlloc_i      (ldqAlloc),
	.stqAlloc_i      (stqAlloc),
	.ldqHead_i       (ldqHead),
	.ldqTail_i       (ldqTail),
	.stqHead_i       (stqHead),
	.stqTail_i       (stqTail),
	.commitSt_i      (commitSt_i),
	.wbPkt_o         (wb),
	.vioPkt_o        (vio),
	.ldEn_o          (ldEn_o),
	.ldAddr_o        (ldAddr_o),
	.ldData_i        (ldData_i),
	.stEn_o          (stEn_o),
	.stAddr_o        (stAddr_o),
	.stData_o        (stData_o),
	.stStall_i       (stStall_i),
	.stDrained_o     (stDrained),
	.stallStCommit_o (stallStCommit_o)
);

// next free entries go back to dispatch
assign ldqId_o     = ldqTail;
assign stqId_o     = stqTail;

assign wbValid_o   = wb.valid;
assign wbIsLoad_o  = wb.isLoad;
assign wbSeqNo_o   = wb.seqNo;
assign wbPhyDest_o = wb.phyDest;
assign wbData_o    = wb.data;
assign vioValid_o  = vio.valid;
assign vioSeqNo_o  = vio.seqNo;

endmodule
